//--- run.sh
#!/bin/sh
# Build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tbLoadStore \
    --Mdir "$BUILD_DIR" \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VtbLoadStore" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sources.f
verilog/StorePkg.sv
verilog/RangeMaskGen.sv
verilog/StoreForward.sv
verilog/StoreQueue.sv
verilog/DataRam.sv
verilog/LoadStoreUnit.sv
verif/tbClock.sv
verif/tbLoadStore.sv

//--- verif/tbClock.sv
`default_nettype none

module tbClock (
    output logic clk
);

    // Period of 4
    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- verif/tbLoadStore.sv
`default_nettype none

module tbLoadStore;

    import StorePkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam int WATCHDOG_CYCLES = 5000;

    logic clk;
    logic rst;
    StAddrUop stAddr;
    StDataUop stData;
    LoadUop load;
    SqN comSqN;
    BranchInfo branch;
    logic memStall;
    LoadResult loadResult;
    logic sqEmpty;
    logic sqDone;
    SqN maxStoreSqN;

    int seed = 6443;
    int testErrors;
    int errors;
    int testsRun;
    int testsFailed;

    // Reference model of drained memory plus uncommitted stores by sequence number
    logic [31:0] refMem [64];
    logic [31:0] mAddr [16];
    logic [3:0] mMask [16];
    logic [31:0] mData [16];
    logic mHasData [16];
    logic mLive [16];
    SqN nextSqN;
    SqN refCom;

    tbClock clockGen (
        .clk(clk)
    );

    LoadStoreUnit dut (
        .clk(clk),
        .rst(rst),
        .stAddr(stAddr),
        .stData(stData),
        .load(load),
        .comSqN(comSqN),
        .branch(branch),
        .memStall(memStall),
        .loadResult(loadResult),
        .sqEmpty(sqEmpty),
        .sqDone(sqDone),
        .maxStoreSqN(maxStoreSqN)
    );

    function automatic logic [3:0] readBytes(input logic [31:0] addr, input MemSize size);
        logic [3:0] mask;
        case (size)
            SIZE_BYTE: mask = 4'b0001 << addr[1:0];
            SIZE_HALF: mask = addr[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    task checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            testErrors++;
        end
    endtask

    task checkFlag(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            testErrors++;
        end
    endtask

    task finishTest(input string name);
        testsRun++;
        if (testErrors == 0) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            testsFailed++;
            $display("[%0t] %s: %0d errors", $time, name, testErrors);
        end
        errors += testErrors;
    endtask

    task sendAddr(input SqN sqn, input logic [31:0] addr, input logic [3:0] wmask);
        @(posedge clk);
        stAddr <= StAddrUop'{valid: 1'b1, storeSqN: sqn, addr: addr, wmask: wmask};
        @(posedge clk);
        stAddr.valid <= 1'b0;
        mAddr[sqn] = addr;
        mMask[sqn] = wmask;
        mHasData[sqn] = 1'b0;
        mLive[sqn] = 1'b1;
    endtask

    task sendData(input SqN sqn, input logic [31:0] data);
        @(posedge clk);
        stData <= StDataUop'{valid: 1'b1, storeSqN: sqn, data: data};
        @(posedge clk);
        stData.valid <= 1'b0;
        mData[sqn] = data;
        mHasData[sqn] = 1'b1;
    endtask

    task sendStore(input logic [31:0] addr, input logic [3:0] wmask, input logic [31:0] data);
        sendAddr(nextSqN, addr, wmask);
        sendData(nextSqN, data);
        nextSqN = nextSqN + 4'd1;
    endtask

    // Committed stores go straight into the memory image in order
    task commitUpTo(input SqN upTo);
        while (refCom != upTo) begin
            for (int b = 0; b < 4; b++) begin
                if (mMask[refCom][b]) begin
                    refMem[mAddr[refCom][7:2]][b*8 +: 8] = mData[refCom][b*8 +: 8];
                end
            end
            mLive[refCom] = 1'b0;
            refCom = refCom + 4'd1;
        end
        @(posedge clk);
        comSqN <= upTo;
    endtask

    task takeBranch(input SqN keep);
        SqN s;
        @(posedge clk);
        branch <= BranchInfo'{taken: 1'b1, storeSqN: keep};
        @(posedge clk);
        branch.taken <= 1'b0;
        s = keep + 4'd1;
        while (s != nextSqN) begin
            mLive[s] = 1'b0;
            s = s + 4'd1;
        end
        nextSqN = keep + 4'd1;
    endtask

    task waitDone();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!sqDone && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (sqDone) else begin
            $display("Store queue did not drain within %0d cycles at %0t", WAIT_LIMIT, $time);
            testErrors++;
        end
    endtask

    // Walks oldest to youngest so the youngest older store wins each byte
    task predictLoad(input SqN ldSqN, input logic [31:0] addr, input MemSize size,
            output logic [31:0] data, output logic conflict);
        logic [3:0] rmask;
        SqN s;
        SqN span;
        rmask = readBytes(addr, size);
        data = refMem[addr[7:2]];
        conflict = 1'b0;
        s = refCom;
        span = ldSqN + 4'd1 - refCom;
        for (int k = 0; k < int'(span); k++) begin
            if (mLive[s] && mAddr[s][31:2] == addr[31:2]) begin
                if (mHasData[s]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mMask[s][b]) begin
                            data[b*8 +: 8] = mData[s][b*8 +: 8];
                        end
                    end
                end else if ((mMask[s] & rmask) != 4'b0000) begin
                    conflict = 1'b1;
                end
            end
            s = s + 4'd1;
        end
        for (int b = 0; b < 4; b++) begin
            if (!rmask[b]) begin
                data[b*8 +: 8] = 8'h00;
            end
        end
    endtask

    task loadCheck(input SqN ldSqN, input logic [31:0] addr, input MemSize size);
        logic [31:0] expData;
        logic expConflict;
        predictLoad(ldSqN, addr, size, expData, expConflict);
        @(posedge clk);
        load <= LoadUop'{valid: 1'b1, storeSqN: ldSqN, addr: addr, size: size};
        @(posedge clk);
        load.valid <= 1'b0;
        // Result is registered at the edge that samples the load
        @(negedge clk);
        assert (loadResult.valid) else begin
            $display("Load from %h gave no result one cycle after it was sampled at %0t",
                addr, $time);
            testErrors++;
        end
        checkValue("loadResult.data", loadResult.data, expData);
        checkFlag("loadResult.conflict", loadResult.conflict, expConflict);
    endtask

    task testReset();
        testErrors = 0;
        @(negedge clk);
        checkFlag("loadResult.valid", loadResult.valid, 1'b0);
        checkFlag("sqEmpty", sqEmpty, 1'b1);
        checkValue("maxStoreSqN", {28'd0, maxStoreSqN}, 32'd7);
        finishTest("reset");
    endtask

    // Also fills every word that later tests read
    task testCommitDrain();
        logic [31:0] addrs [8];
        logic [31:0] value;
        SqN expMax;
        testErrors = 0;
        addrs = '{32'h10, 32'h14, 32'h20, 32'h24, 32'h30, 32'h50, 32'h54, 32'h58};
        foreach (addrs[i]) begin
            value = $random(seed);
            sendStore(addrs[i], 4'b1111, value);
            commitUpTo(nextSqN);
            waitDone();
            loadCheck(nextSqN - 4'd1, addrs[i], SIZE_WORD);
        end
        expMax = nextSqN + 4'd7;
        checkValue("maxStoreSqN", {28'd0, maxStoreSqN}, {28'd0, expMax});
        finishTest("commit and drain");
    endtask

    task testForwarding();
        SqN olderSqN;
        testErrors = 0;
        olderSqN = nextSqN;
        sendStore(32'h20, 4'b0011, 32'h1111_AAAA);
        sendStore(32'h20, 4'b0110, 32'h22BB_CC33);
        loadCheck(nextSqN - 4'd1, 32'h20, SIZE_BYTE);
        loadCheck(nextSqN - 4'd1, 32'h21, SIZE_BYTE);
        loadCheck(nextSqN - 4'd1, 32'h22, SIZE_BYTE);
        loadCheck(nextSqN - 4'd1, 32'h23, SIZE_BYTE);
        loadCheck(nextSqN - 4'd1, 32'h20, SIZE_HALF);
        loadCheck(nextSqN - 4'd1, 32'h22, SIZE_HALF);
        loadCheck(nextSqN - 4'd1, 32'h20, SIZE_WORD);
        // Load that sits between the two stores
        loadCheck(olderSqN, 32'h20, SIZE_WORD);
        commitUpTo(nextSqN);
        waitDone();
        loadCheck(nextSqN - 4'd1, 32'h20, SIZE_WORD);
        finishTest("forwarding");
    endtask

    task testConflict();
        SqN sqn;
        logic [31:0] value;
        testErrors = 0;
        sqn = nextSqN;
        sendAddr(sqn, 32'h24, 4'b1100);
        nextSqN = nextSqN + 4'd1;
        loadCheck(sqn, 32'h27, SIZE_BYTE);
        loadCheck(sqn, 32'h24, SIZE_HALF);
        loadCheck(sqn, 32'h24, SIZE_WORD);
        value = $random(seed);
        sendData(sqn, value);
        loadCheck(sqn, 32'h24, SIZE_WORD);
        commitUpTo(nextSqN);
        waitDone();
        loadCheck(nextSqN - 4'd1, 32'h24, SIZE_WORD);
        finishTest("conflict");
    endtask

    task testBranch();
        SqN keepSqN;
        testErrors = 0;
        sendStore(32'h30, 4'b1111, $random(seed));
        commitUpTo(nextSqN);
        keepSqN = nextSqN;
        sendStore(32'h14, 4'b0011, $random(seed));
        sendStore(32'h30, 4'b1111, $random(seed));
        sendStore(32'h14, 4'b1111, $random(seed));
        loadCheck(nextSqN - 4'd1, 32'h30, SIZE_WORD);
        takeBranch(keepSqN);
        loadCheck(nextSqN - 4'd1, 32'h30, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h14, SIZE_WORD);
        commitUpTo(nextSqN);
        waitDone();
        loadCheck(nextSqN - 4'd1, 32'h30, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h14, SIZE_WORD);
        // Discarded stores must not linger once the survivors have drained
        checkFlag("sqEmpty", sqEmpty, 1'b1);
        finishTest("branch");
    endtask

    task testBackPressure();
        SqN startMax;
        SqN heldMax;
        SqN expMax;
        int cycles;
        testErrors = 0;
        sendStore(32'h50, 4'b1111, $random(seed));
        sendStore(32'h54, 4'b1111, $random(seed));
        sendStore(32'h50, 4'b0010, $random(seed));
        sendStore(32'h58, 4'b1111, $random(seed));
        @(negedge clk);
        startMax = maxStoreSqN;
        commitUpTo(nextSqN);
        // Stall once the first store has left the queue
        cycles = 0;
        @(negedge clk);
        while (maxStoreSqN == startMax && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (maxStoreSqN != startMax) else begin
            $display("Committed stores never started draining at %0t", $time);
            testErrors++;
        end
        @(posedge clk);
        memStall <= 1'b1;
        @(negedge clk);
        heldMax = maxStoreSqN;
        repeat (6) begin
            @(negedge clk);
            checkValue("maxStoreSqN", {28'd0, maxStoreSqN}, {28'd0, heldMax});
            checkFlag("sqDone", sqDone, 1'b0);
        end
        loadCheck(nextSqN - 4'd1, 32'h50, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h54, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h58, SIZE_WORD);
        checkValue("maxStoreSqN", {28'd0, maxStoreSqN}, {28'd0, heldMax});
        @(posedge clk);
        memStall <= 1'b0;
        waitDone();
        loadCheck(nextSqN - 4'd1, 32'h50, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h54, SIZE_WORD);
        loadCheck(nextSqN - 4'd1, 32'h58, SIZE_WORD);
        expMax = nextSqN + 4'd7;
        checkValue("maxStoreSqN", {28'd0, maxStoreSqN}, {28'd0, expMax});
        finishTest("back-pressure");
    endtask

    initial begin
        rst <= 1'b1;
        stAddr <= '0;
        stData <= '0;
        load <= '0;
        comSqN <= '0;
        branch <= '0;
        memStall <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            mLive[i] = 1'b0;
            mHasData[i] = 1'b0;
        end
        nextSqN = '0;
        refCom = '0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        testReset();
        testCommitDrain();
        testForwarding();
        testConflict();
        testBranch();
        testBackPressure();

        $display("tests=%0d failed=%0d errors=%0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run exceeded %0d cycles and was stopped", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/DataRam.sv
`default_nettype none

module DataRam (
    input wire clk,
    input wire rst,
    input wire StorePkg::SqUop memWrite,
    input wire memStall,
    input wire [29:0] rdAddr,
    input wire rdEn,
    output logic [31:0] rdData
);

    import StorePkg::*;

    logic [31:0] mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] wrIdx;
    logic [$clog2(RAM_WORDS)-1:0] rdIdx;
    logic wrEn;

    assign wrIdx = memWrite.addr[2 +: $clog2(RAM_WORDS)];
    assign rdIdx = rdAddr[$clog2(RAM_WORDS)-1:0];
    assign wrEn = memWrite.valid && !memStall;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (memWrite.wmask[b]) begin
                    mem[wrIdx][b*8 +: 8] <= memWrite.data[b*8 +: 8];
                end
            end
        end
    end

    // Same-address read sees the old word
    always_ff @(posedge clk) begin
        if (rst) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= mem[rdIdx];
        end
    end

    wrAddrInRange: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> memWrite.addr[31:2] < 30'(RAM_WORDS));

    rdAddrInRange: assert property (@(posedge clk) disable iff (rst)
        rdEn |-> rdAddr < 30'(RAM_WORDS));

endmodule

`default_nettype wire

//--- verilog/LoadStoreUnit.sv
`default_nettype none

module LoadStoreUnit (
    input wire clk,
    input wire rst,
    input wire StorePkg::StAddrUop stAddr,
    input wire StorePkg::StDataUop stData,
    input wire StorePkg::LoadUop load,
    input wire StorePkg::SqN comSqN,
    input wire StorePkg::BranchInfo branch,
    input wire memStall,
    output StorePkg::LoadResult loadResult,
    output logic sqEmpty,
    output logic sqDone,
    output StorePkg::SqN maxStoreSqN
);

    import StorePkg::*;

    SqUop memWrite;
    FwdResult fwd;
    logic [31:0] rdData;

    StoreQueue sq (
        .clk(clk),
        .rst(rst),
        .stAddr(stAddr),
        .stData(stData),
        .load(load),
        .comSqN(comSqN),
        .branch(branch),
        .memStall(memStall),
        .memWrite(memWrite),
        .fwd(fwd),
        .empty(sqEmpty),
        .done(sqDone),
        .maxStoreSqN(maxStoreSqN)
    );

    DataRam ram (
        .clk(clk),
        .rst(rst),
        .memWrite(memWrite),
        .memStall(memStall),
        .rdAddr(load.addr[31:2]),
        .rdEn(load.valid),
        .rdData(rdData)
    );

    // Unread bytes arrive masked and zeroed from the queue
    always_comb begin
        loadResult.valid = fwd.valid;
        loadResult.conflict = fwd.conflict;
        for (int b = 0; b < 4; b++) begin
            if (fwd.mask[b]) begin
                loadResult.data[b*8 +: 8] = fwd.data[b*8 +: 8];
            end else begin
                loadResult.data[b*8 +: 8] = rdData[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/RangeMaskGen.sv
`default_nettype none

module RangeMaskGen (
    input wire [StorePkg::IDX_LEN-1:0] startIdx,
    input wire [StorePkg::IDX_LEN-1:0] endIdx,
    input wire allOnes,
    output logic [StorePkg::SQ_ENTRIES-1:0] range
);

    import StorePkg::*;

    logic wraps;

    // End before start means the range crosses slot 0
    assign wraps = endIdx < startIdx;

    always_comb begin
        logic [IDX_LEN-1:0] slot;
        logic afterStart;
        logic beforeEnd;

        for (int i = 0; i < SQ_ENTRIES; i++) begin
            slot = IDX_LEN'(i);
            afterStart = slot >= startIdx;
            beforeEnd = slot < endIdx;

            if (allOnes) begin
                range[i] = 1'b1;
            end else if (wraps) begin
                range[i] = afterStart || beforeEnd;
            end else begin
                range[i] = afterStart && beforeEnd;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/StoreForward.sv
`default_nettype none

module StoreForward (
    input wire StorePkg::SqEntry [StorePkg::SQ_ENTRIES-1:0] entries,
    input wire [StorePkg::IDX_LEN-1:0] baseIdx,
    input wire [31:0] lookupAddr,
    input wire [3:0] readMask,
    input wire [StorePkg::SQ_ENTRIES-1:0] fwdRange,
    input wire [StorePkg::SQ_ENTRIES-1:0] readyMask,
    output logic [31:0] fwdData,
    output logic [3:0] fwdMask,
    output logic conflict
);

    import StorePkg::*;

    logic [SQ_ENTRIES-1:0] older;
    logic [SQ_ENTRIES-1:0] addrMatch;

    // Committed slots are always older than the load
    assign older = fwdRange | readyMask;

    always_comb begin
        for (int i = 0; i < SQ_ENTRIES; i++) begin
            addrMatch[i] = entries[i].addrAvail && older[i]
                && (entries[i].addr == lookupAddr[31:2]);
        end
    end

    // Chain starts empty at the base and writes the youngest matching store last
    always_comb begin
        logic [IDX_LEN-1:0] idx;
        logic [3:0] wmask;

        fwdData = '0;
        fwdMask = '0;
        conflict = 1'b0;

        for (int k = 0; k < SQ_ENTRIES; k++) begin
            idx = baseIdx + IDX_LEN'(k);
            wmask = entries[idx].wmask;

            if (addrMatch[idx]) begin
                if (entries[idx].loaded) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wmask[b]) begin
                            fwdData[b*8 +: 8] = entries[idx].data[b*8 +: 8];
                        end
                    end
                    fwdMask = fwdMask | wmask;
                end else if ((wmask & readMask) != 4'b0000) begin
                    // Address known but data still missing
                    conflict = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/StorePkg.sv
`default_nettype none

package StorePkg;

    localparam int SQ_ENTRIES = 8;
    localparam int IDX_LEN = 3;
    // Extra bit tells a full queue from an empty one
    localparam int SQN_LEN = IDX_LEN + 1;
    localparam int RAM_WORDS = 64;

    typedef logic [SQN_LEN-1:0] SqN;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } MemSize;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] addr;
        logic [3:0] wmask;
    } StAddrUop;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] data;
    } StDataUop;

    // storeSqN is the youngest store older than the load
    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] addr;
        MemSize size;
    } LoadUop;

    // storeSqN is the youngest store that survives the mispredict
    typedef struct packed {
        logic taken;
        SqN storeSqN;
    } BranchInfo;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } SqUop;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        logic [3:0] mask;
        logic conflict;
    } FwdResult;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        logic conflict;
    } LoadResult;

    // Queue slot that keeps the word address only
    typedef struct packed {
        logic [31:0] data;
        logic [29:0] addr;
        logic [3:0] wmask;
        logic loaded;
        logic addrAvail;
    } SqEntry;

endpackage

`default_nettype wire

//--- verilog/StoreQueue.sv
`default_nettype none

module StoreQueue (
    input wire clk,
    input wire rst,
    input wire StorePkg::StAddrUop stAddr,
    input wire StorePkg::StDataUop stData,
    input wire StorePkg::LoadUop load,
    input wire StorePkg::SqN comSqN,
    input wire StorePkg::BranchInfo branch,
    input wire memStall,
    output StorePkg::SqUop memWrite,
    output StorePkg::FwdResult fwd,
    output logic empty,
    output logic done,
    output StorePkg::SqN maxStoreSqN
);

    import StorePkg::*;

    SqEntry [SQ_ENTRIES-1:0] entries;
    SqN baseIndex;
    SqN nextBaseIndex;
    logic [IDX_LEN-1:0] baseIdx;
    logic [SQ_ENTRIES-1:0] entryReady;
    logic [SQ_ENTRIES-1:0] readyRange;
    logic [SQ_ENTRIES-1:0] invalRange;
    logic [SQ_ENTRIES-1:0] fwdRangeRaw;
    logic [SQ_ENTRIES-1:0] fwdRange;
    SqN comAhead;
    SqN brAhead;
    SqN ldAhead;
    SqN addrAhead;
    SqN addrPastBranch;
    SqN dataPastBranch;
    logic addrTake;
    logic dataTake;
    logic [IDX_LEN-1:0] addrIdx;
    logic [IDX_LEN-1:0] dataIdx;
    SqEntry deqEntry;
    logic deqReady;
    logic doDeq;
    logic emptyNow;
    logic [3:0] readMask;
    logic [31:0] chainData;
    logic [3:0] chainMask;
    logic chainConflict;
    logic mwHit;
    logic [31:0] lookupData;
    logic [3:0] lookupMask;

    assign baseIdx = baseIndex[IDX_LEN-1:0];
    assign done = baseIndex == comSqN;

    // Strobes younger than a taken branch are dropped
    assign addrPastBranch = stAddr.storeSqN - branch.storeSqN;
    assign dataPastBranch = stData.storeSqN - branch.storeSqN;
    assign addrTake = stAddr.valid && !(branch.taken && $signed(addrPastBranch) > 0);
    assign dataTake = stData.valid && !(branch.taken && $signed(dataPastBranch) > 0);
    assign addrIdx = stAddr.storeSqN[IDX_LEN-1:0];
    assign dataIdx = stData.storeSqN[IDX_LEN-1:0];

    assign deqEntry = entries[baseIdx];
    assign deqReady = entryReady[baseIdx] && deqEntry.addrAvail && deqEntry.loaded;
    assign doDeq = deqReady && !memStall;
    assign nextBaseIndex = baseIndex + SqN'(doDeq);

    // Ready mask is taken against the next base so a freed slot never stays ready
    assign comAhead = comSqN - nextBaseIndex;
    RangeMaskGen readyRangeGen (
        .startIdx(nextBaseIndex[IDX_LEN-1:0]),
        .endIdx(comSqN[IDX_LEN-1:0]),
        .allOnes(comAhead == SqN'(SQ_ENTRIES)),
        .range(readyRange)
    );

    // Branch older than every queued store clears the whole queue
    assign brAhead = branch.storeSqN - baseIndex;
    RangeMaskGen invalRangeGen (
        .startIdx(branch.storeSqN[IDX_LEN-1:0] + IDX_LEN'(1)),
        .endIdx(baseIdx),
        .allOnes($signed(brAhead) < 0),
        .range(invalRange)
    );

    assign ldAhead = load.storeSqN - baseIndex;
    RangeMaskGen fwdRangeGen (
        .startIdx(baseIdx),
        .endIdx(load.storeSqN[IDX_LEN-1:0] + IDX_LEN'(1)),
        .allOnes(ldAhead == SqN'(SQ_ENTRIES - 1)),
        .range(fwdRangeRaw)
    );
    // No uncommitted older store left in the queue
    assign fwdRange = ($signed(ldAhead) < 0) ? '0 : fwdRangeRaw;

    always_comb begin
        case (load.size)
            SIZE_BYTE: readMask = 4'b0001 << load.addr[1:0];
            SIZE_HALF: readMask = load.addr[1] ? 4'b1100 : 4'b0011;
            default: readMask = 4'b1111;
        endcase
    end

    StoreForward forward (
        .entries(entries),
        .baseIdx(baseIdx),
        .lookupAddr(load.addr),
        .readMask(readMask),
        .fwdRange(fwdRange),
        .readyMask(entryReady),
        .fwdData(chainData),
        .fwdMask(chainMask),
        .conflict(chainConflict)
    );

    // Store in memWrite is older than anything still queued
    assign mwHit = memWrite.valid && (memWrite.addr[31:2] == load.addr[31:2]);
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (!readMask[b]) begin
                lookupData[b*8 +: 8] = 8'h00;
            end else if (chainMask[b]) begin
                lookupData[b*8 +: 8] = chainData[b*8 +: 8];
            end else if (mwHit && memWrite.wmask[b]) begin
                lookupData[b*8 +: 8] = memWrite.data[b*8 +: 8];
            end else begin
                lookupData[b*8 +: 8] = 8'h00;
            end
        end
        lookupMask = ~readMask | chainMask | (mwHit ? memWrite.wmask : 4'b0000);
    end

    always_comb begin
        emptyNow = 1'b1;
        for (int i = 0; i < SQ_ENTRIES; i++) begin
            if (entries[i].addrAvail) begin
                emptyNow = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryReady <= '0;
        end else begin
            entryReady <= readyRange;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SQ_ENTRIES; i++) begin
                entries[i].addrAvail <= 1'b0;
                entries[i].loaded <= 1'b0;
            end
        end else begin
            if (doDeq) begin
                entries[baseIdx].addrAvail <= 1'b0;
                entries[baseIdx].loaded <= 1'b0;
            end
            if (dataTake) begin
                entries[dataIdx].data <= stData.data;
                entries[dataIdx].loaded <= 1'b1;
            end
            if (branch.taken) begin
                for (int i = 0; i < SQ_ENTRIES; i++) begin
                    if (invalRange[i] && !entryReady[i]) begin
                        entries[i].addrAvail <= 1'b0;
                        entries[i].loaded <= 1'b0;
                    end
                end
            end
            if (addrTake) begin
                entries[addrIdx].addr <= stAddr.addr[31:2];
                entries[addrIdx].wmask <= stAddr.wmask;
                entries[addrIdx].addrAvail <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            maxStoreSqN <= SqN'(SQ_ENTRIES - 1);
            empty <= 1'b1;
            memWrite.valid <= 1'b0;
            fwd.valid <= 1'b0;
        end else begin
            baseIndex <= nextBaseIndex;
            maxStoreSqN <= nextBaseIndex + SqN'(SQ_ENTRIES - 1);
            empty <= emptyNow && !addrTake;
            // Held as is while memory stalls
            if (!memStall) begin
                memWrite <= SqUop'{
                    valid: deqReady,
                    addr: {deqEntry.addr, 2'b00},
                    data: deqEntry.data,
                    wmask: deqEntry.wmask
                };
            end
            fwd <= FwdResult'{
                valid: load.valid,
                data: lookupData,
                mask: lookupMask,
                conflict: chainConflict
            };
        end
    end

    assign addrAhead = stAddr.storeSqN - maxStoreSqN;

    addrSlotFree: assert property (@(posedge clk) disable iff (rst)
        addrTake |-> !entries[addrIdx].addrAvail);

    addrInWindow: assert property (@(posedge clk) disable iff (rst)
        stAddr.valid |-> $signed(addrAhead) <= 0);

endmodule

`default_nettype wire
